//--- verilog/msr_defines.svh
// Architecture constants of the machine-state register block
// Data and PSR widths, scratch register count, exception vector
// alignment, CPUID fields and the default command queue depth

`ifndef MSR_DEFINES_SVH
`define MSR_DEFINES_SVH

// Machine word
`define MSR_XLEN 64

// PSR image with bits 3..0 always zero
`define MSR_PSR_W 10

// Scratch registers SR0..SR3
`define MSR_SR_NUM 4

// EVECT keeps bits 63..12 only
`define MSR_EVECT_LSB 12

// CPUID fields packed as version, revision and features from bit 0 up
`define MSR_CPUID_VER 8'h01
`define MSR_CPUID_REV 10'h000
`define MSR_CPUID_FEAT 8'hc3

// Command queue entries
`define MSR_QUEUE_DEPTH 4

`endif

//--- verilog/msr_pkg.sv
// Shared types of the machine-state register block
// Operation and address codes, command and response records,
// and the PSR layout

`default_nettype none

`include "msr_defines.svh"

package msr_pkg;

   // Machine-state operations
   typedef enum logic [1:0] {
      OP_READ,
      OP_WRITE,
      OP_SAVE,
      OP_RESTORE
   } msr_op_e;

   // Register map with codes 7 and 12..15 unmapped
   typedef enum logic [3:0] {
      A_PSR    = 4'h0,
      A_EPSR   = 4'h1,
      A_EPC    = 4'h2,
      A_ELSA   = 4'h3,
      A_EVECT  = 4'h4,
      A_CPUID  = 4'h5,
      A_COREID = 4'h6,
      A_SR0    = 4'h8,
      A_SR1    = 4'h9,
      A_SR2    = 4'ha,
      A_SR3    = 4'hb
   } msr_addr_e;

   typedef struct packed {
      msr_op_e                op;
      msr_addr_e              addr;
      logic [`MSR_XLEN-1:0]   data;
   } msr_cmd_t;

   typedef struct packed {
      msr_op_e                op;
      logic [`MSR_XLEN-1:0]   data;
   } msr_rsp_t;

   // Bit 9 down to bit 4 followed by four zero bits
   typedef struct packed {
      logic       dce;
      logic       ice;
      logic       dmme;
      logic       imme;
      logic       ire;
      logic       rm;
      logic [3:0] rsvd;
   } psr_t;

endpackage

`default_nettype wire

//--- verilog/msr_cmd_intake.sv
// Command intake
// Four-phase slave on the command port. Captures the command when
// req rises, pushes it into the queue once there is room, then holds
// ack until the master drops req

`timescale 1ns/1ps
`default_nettype none

module msr_cmd_intake (
   input  logic              clk,
   input  logic              rst,
   input  logic              cmd_req,
   input  msr_pkg::msr_cmd_t cmd,
   output logic              cmd_ack,
   output logic              push,
   output msr_pkg::msr_cmd_t push_cmd,
   input  logic              full
);

   typedef enum logic [1:0] {
      st_idle,
      st_push,
      st_wait_drop
   } state_e;

   state_e state;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (cmd_req) begin
                  state <= st_push;
               end
            end
            // Stall here while the queue is full
            st_push: begin
               if (!full) begin
                  state <= st_wait_drop;
               end
            end
            st_wait_drop: begin
               if (!cmd_req) begin
                  state <= st_idle;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // Take the command on the rising req while the master holds it stable
   always_ff @(posedge clk) begin
      if (state == st_idle && cmd_req) begin
         push_cmd <= cmd;
      end
   end

   // Exactly one push per handshake
   assign push = (state == st_push) && !full;

   assign cmd_ack = (state == st_wait_drop);

endmodule

`default_nettype wire

//--- verilog/msr_cmd_queue.sv
// Command queue
// Synchronous FIFO of machine-state commands as a circular buffer with
// read and write pointers and an occupancy count. Any depth of 2 or more

`timescale 1ns/1ps
`default_nettype none

`include "msr_defines.svh"

module msr_cmd_queue #(
   parameter int depth = `MSR_QUEUE_DEPTH
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              push,
   input  msr_pkg::msr_cmd_t push_cmd,
   output logic              full,
   input  logic              pop,
   output msr_pkg::msr_cmd_t head,
   output logic              empty
);
   import msr_pkg::*;

   localparam int ptr_w = $clog2(depth);
   localparam int cnt_w = $clog2(depth + 1);

   msr_cmd_t         mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             do_push;
   logic             do_pop;

   // Wraps at depth-1 so depths that are not a power of two work
   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
      if (ptr == ptr_w'(depth - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_cmd;
      end
   end

   assign head  = mem[rd_ptr];
   assign full  = (count == cnt_w'(depth));
   assign empty = (count == '0);

endmodule

`default_nettype wire

//--- verilog/msr_state.sv
// Machine-state register file
// PSR, EPSR, EPC, ELSA, EVECT and the scratch registers, with the
// exception save and restore sequences. All outputs are bypassed, so
// a value written this cycle is already visible. CPUID and COREID
// are constants

`timescale 1ns/1ps
`default_nettype none

`include "msr_defines.svh"

module msr_state (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   psr_save,
   input  logic                                   psr_restore,
   input  logic                                   psr_we,
   input  logic                                   epsr_we,
   input  logic                                   epc_we,
   input  logic                                   elsa_we,
   input  logic                                   evect_we,
   input  logic [`MSR_SR_NUM-1:0]                 sr_we,
   input  logic [`MSR_XLEN-1:0]                   wdata,
   output msr_pkg::psr_t                          psr,
   output msr_pkg::psr_t                          epsr,
   output logic [`MSR_XLEN-1:0]                   epc,
   output logic [`MSR_XLEN-1:0]                   elsa,
   output logic [`MSR_XLEN-1:0]                   evect,
   output logic [`MSR_XLEN-1:0]                   cpuid,
   output logic [`MSR_XLEN-1:0]                   coreid,
   output logic [`MSR_SR_NUM-1:0][`MSR_XLEN-1:0]  sr
);
   import msr_pkg::*;

   localparam psr_t psr_rst = '{rm: 1'b1, default: '0};

   psr_t                                  psr_ff;
   psr_t                                  epsr_ff;
   psr_t                                  psr_wr;
   psr_t                                  psr_nold;
   psr_t                                  psr_nxt;
   psr_t                                  epsr_nxt;
   logic                                  epsr_ld;
   logic                                  epc_ld;
   logic [`MSR_XLEN-1:0]                  epc_ff;
   logic [`MSR_XLEN-1:0]                  elsa_ff;
   logic [`MSR_XLEN-1:`MSR_EVECT_LSB]     evect_ff;
   logic [`MSR_SR_NUM-1:0][`MSR_XLEN-1:0] sr_ff;

   // Write data as a PSR image with reserved bits forced low
   assign psr_wr = psr_t'({wdata[`MSR_PSR_W-1:4], 4'b0000});

   always_comb begin
      // PSR as it would be without a save
      psr_nold = psr_ff;
      if (psr_we) begin
         psr_nold = psr_wr;
      end
      // Restore leaves the cache enables alone
      if (psr_restore) begin
         psr_nold.rm   = epsr_ff.rm;
         psr_nold.ire  = epsr_ff.ire;
         psr_nold.imme = epsr_ff.imme;
         psr_nold.dmme = epsr_ff.dmme;
      end
      // Exception entry goes to kernel mode with interrupts and translation off
      psr_nxt = psr_nold;
      if (psr_save) begin
         psr_nxt.rm   = 1'b1;
         psr_nxt.ire  = 1'b0;
         psr_nxt.imme = 1'b0;
         psr_nxt.dmme = 1'b0;
      end
   end

   assign epsr_ld  = epsr_we || psr_save;
   assign epsr_nxt = psr_save ? psr_nold : psr_wr;
   assign epc_ld   = epc_we || psr_save;

   always_ff @(posedge clk) begin
      if (rst) begin
         psr_ff   <= psr_rst;
         epsr_ff  <= '0;
         epc_ff   <= '0;
         elsa_ff  <= '0;
         evect_ff <= '0;
         sr_ff    <= '0;
      end else begin
         psr_ff <= psr_nxt;
         if (epsr_ld) begin
            epsr_ff <= epsr_nxt;
         end
         if (epc_ld) begin
            epc_ff <= wdata;
         end
         if (elsa_we) begin
            elsa_ff <= wdata;
         end
         if (evect_we) begin
            evect_ff <= wdata[`MSR_XLEN-1:`MSR_EVECT_LSB];
         end
         for (int i = 0; i < `MSR_SR_NUM; i++) begin
            if (sr_we[i]) begin
               sr_ff[i] <= wdata;
            end
         end
      end
   end

   // Bypassed read side
   assign psr  = psr_nxt;
   assign epsr = epsr_ld ? epsr_nxt : epsr_ff;
   assign epc  = epc_ld ? wdata : epc_ff;
   assign elsa = elsa_we ? wdata : elsa_ff;

   assign evect = {evect_we ? wdata[`MSR_XLEN-1:`MSR_EVECT_LSB] : evect_ff,
                   {`MSR_EVECT_LSB{1'b0}}};

   always_comb begin
      for (int i = 0; i < `MSR_SR_NUM; i++) begin
         sr[i] = sr_we[i] ? wdata : sr_ff[i];
      end
   end

   assign cpuid  = {{(`MSR_XLEN-26){1'b0}}, `MSR_CPUID_FEAT, `MSR_CPUID_REV, `MSR_CPUID_VER};
   assign coreid = '0;

endmodule

`default_nettype wire

//--- verilog/msr_exec.sv
// Command executor
// Pops one command per cycle, reads the addressed register before
// the update lands, then drives the state file controls from a
// one-entry stage. Responses leave in command order, one cycle later

`timescale 1ns/1ps
`default_nettype none

`include "msr_defines.svh"

module msr_exec (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   empty,
   input  msr_pkg::msr_cmd_t                      head,
   output logic                                   pop,
   output logic                                   psr_save,
   output logic                                   psr_restore,
   output logic                                   psr_we,
   output logic                                   epsr_we,
   output logic                                   epc_we,
   output logic                                   elsa_we,
   output logic                                   evect_we,
   output logic [`MSR_SR_NUM-1:0]                 sr_we,
   output logic [`MSR_XLEN-1:0]                   wdata,
   input  msr_pkg::psr_t                          psr,
   input  msr_pkg::psr_t                          epsr,
   input  logic [`MSR_XLEN-1:0]                   epc,
   input  logic [`MSR_XLEN-1:0]                   elsa,
   input  logic [`MSR_XLEN-1:0]                   evect,
   input  logic [`MSR_XLEN-1:0]                   cpuid,
   input  logic [`MSR_XLEN-1:0]                   coreid,
   input  logic [`MSR_SR_NUM-1:0][`MSR_XLEN-1:0]  sr,
   output logic                                   rsp_valid,
   output msr_pkg::msr_rsp_t                      rsp
);
   import msr_pkg::*;

   logic                 stg_valid;
   msr_cmd_t             stg_cmd;
   logic [`MSR_XLEN-1:0] stg_data;
   logic [`MSR_XLEN-1:0] reg_val;
   logic [`MSR_XLEN-1:0] rsp_data;
   logic                 wr_en;

   assign pop = !empty;

   // Register read for the head command sees the staged update via bypass
   always_comb begin
      case (head.addr)
         A_PSR:    reg_val = {{(`MSR_XLEN-`MSR_PSR_W){1'b0}}, psr};
         A_EPSR:   reg_val = {{(`MSR_XLEN-`MSR_PSR_W){1'b0}}, epsr};
         A_EPC:    reg_val = epc;
         A_ELSA:   reg_val = elsa;
         A_EVECT:  reg_val = evect;
         A_CPUID:  reg_val = cpuid;
         A_COREID: reg_val = coreid;
         A_SR0, A_SR1, A_SR2, A_SR3: begin
            reg_val = sr[2'(head.addr - A_SR0)];
         end
         default:  reg_val = '0;
      endcase
   end

   // Save returns the handler address and restore the return address
   always_comb begin
      case (head.op)
         OP_SAVE:    rsp_data = evect;
         OP_RESTORE: rsp_data = epc;
         default:    rsp_data = reg_val;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         stg_valid <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         stg_valid <= pop;
         rsp_valid <= stg_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         stg_cmd  <= head;
         stg_data <= rsp_data;
      end
      rsp.op   <= stg_cmd.op;
      rsp.data <= stg_data;
   end

   // Controls for the staged command take effect at the response edge
   assign wr_en       = stg_valid && (stg_cmd.op == OP_WRITE);
   assign psr_save    = stg_valid && (stg_cmd.op == OP_SAVE);
   assign psr_restore = stg_valid && (stg_cmd.op == OP_RESTORE);
   assign psr_we      = wr_en && (stg_cmd.addr == A_PSR);
   assign epsr_we     = wr_en && (stg_cmd.addr == A_EPSR);
   assign epc_we      = wr_en && (stg_cmd.addr == A_EPC);
   assign elsa_we     = wr_en && (stg_cmd.addr == A_ELSA);
   assign evect_we    = wr_en && (stg_cmd.addr == A_EVECT);

   always_comb begin
      for (int i = 0; i < `MSR_SR_NUM; i++) begin
         sr_we[i] = wr_en && (stg_cmd.addr == msr_addr_e'(A_SR0 + i));
      end
   end

   // Also carries the EPC value on a save
   assign wdata = stg_cmd.data;

endmodule

`default_nettype wire

//--- verilog/msr_unit.sv
// Top level of the machine-state unit
// Command intake and queue feed the executor, which drives the
// state register file and returns one response per command

`timescale 1ns/1ps
`default_nettype none

`include "msr_defines.svh"

module msr_unit (
   input  logic              clk,
   input  logic              rst,
   input  logic              cmd_req,
   input  msr_pkg::msr_cmd_t cmd,
   output logic              cmd_ack,
   output logic              rsp_valid,
   output msr_pkg::msr_rsp_t rsp
);
   import msr_pkg::*;

   msr_cmd_t                              push_cmd;
   msr_cmd_t                              head;
   logic                                  push;
   logic                                  full;
   logic                                  pop;
   logic                                  empty;
   logic                                  psr_save;
   logic                                  psr_restore;
   logic                                  psr_we;
   logic                                  epsr_we;
   logic                                  epc_we;
   logic                                  elsa_we;
   logic                                  evect_we;
   logic [`MSR_SR_NUM-1:0]                sr_we;
   logic [`MSR_XLEN-1:0]                  wdata;
   psr_t                                  psr;
   psr_t                                  epsr;
   logic [`MSR_XLEN-1:0]                  epc;
   logic [`MSR_XLEN-1:0]                  elsa;
   logic [`MSR_XLEN-1:0]                  evect;
   logic [`MSR_XLEN-1:0]                  cpuid;
   logic [`MSR_XLEN-1:0]                  coreid;
   logic [`MSR_SR_NUM-1:0][`MSR_XLEN-1:0] sr;

   msr_cmd_intake intake_i (
      .clk      (clk),
      .rst      (rst),
      .cmd_req  (cmd_req),
      .cmd      (cmd),
      .cmd_ack  (cmd_ack),
      .push     (push),
      .push_cmd (push_cmd),
      .full     (full)
   );

   msr_cmd_queue #(.depth(`MSR_QUEUE_DEPTH)) queue_i (
      .clk      (clk),
      .rst      (rst),
      .push     (push),
      .push_cmd (push_cmd),
      .full     (full),
      .pop      (pop),
      .head     (head),
      .empty    (empty)
   );

   msr_exec exec_i (
      .clk         (clk),
      .rst         (rst),
      .empty       (empty),
      .head        (head),
      .pop         (pop),
      .psr_save    (psr_save),
      .psr_restore (psr_restore),
      .psr_we      (psr_we),
      .epsr_we     (epsr_we),
      .epc_we      (epc_we),
      .elsa_we     (elsa_we),
      .evect_we    (evect_we),
      .sr_we       (sr_we),
      .wdata       (wdata),
      .psr         (psr),
      .epsr        (epsr),
      .epc         (epc),
      .elsa        (elsa),
      .evect       (evect),
      .cpuid       (cpuid),
      .coreid      (coreid),
      .sr          (sr),
      .rsp_valid   (rsp_valid),
      .rsp         (rsp)
   );

   msr_state state_i (
      .clk         (clk),
      .rst         (rst),
      .psr_save    (psr_save),
      .psr_restore (psr_restore),
      .psr_we      (psr_we),
      .epsr_we     (epsr_we),
      .epc_we      (epc_we),
      .elsa_we     (elsa_we),
      .evect_we    (evect_we),
      .sr_we       (sr_we),
      .wdata       (wdata),
      .psr         (psr),
      .epsr        (epsr),
      .epc         (epc),
      .elsa        (elsa),
      .evect       (evect),
      .cpuid       (cpuid),
      .coreid      (coreid),
      .sr          (sr)
   );

endmodule

`default_nettype wire

//--- tests/msr_model.svh
// Reference model of the machine-state registers
// Keeps a shadow copy of the register file and returns the response
// each command should produce, updating the shadow as it goes

`ifndef MSR_MODEL_SVH
`define MSR_MODEL_SVH

psr_t                 m_psr;
psr_t                 m_epsr;
logic [`MSR_XLEN-1:0] m_epc;
logic [`MSR_XLEN-1:0] m_elsa;
logic [`MSR_XLEN-1:0] m_evect;
logic [`MSR_XLEN-1:0] m_sr [`MSR_SR_NUM];

// State after reset with only kernel mode set
function automatic void clear_shadow();
   m_psr    = '0;
   m_psr.rm = 1'b1;
   m_epsr   = '0;
   m_epc    = '0;
   m_elsa   = '0;
   m_evect  = '0;
   for (int i = 0; i < `MSR_SR_NUM; i++) begin
      m_sr[i] = '0;
   end
endfunction

// PSR image from bits 4..9 of a data word with the low four bits zero
function automatic psr_t psr_image(input logic [`MSR_XLEN-1:0] d);
   psr_t p;
   p      = '0;
   p.rm   = d[4];
   p.ire  = d[5];
   p.imme = d[6];
   p.dmme = d[7];
   p.ice  = d[8];
   p.dce  = d[9];
   return p;
endfunction

// Version in bits 7..0, revision in bits 17..8, features in bits 25..18
function automatic logic [`MSR_XLEN-1:0] cpuid_word();
   logic [`MSR_XLEN-1:0] v;
   v = 64'(`MSR_CPUID_VER);
   v = v | (64'(`MSR_CPUID_REV) << 8);
   v = v | (64'(`MSR_CPUID_FEAT) << 18);
   return v;
endfunction

function automatic logic [`MSR_XLEN-1:0] read_shadow(input msr_addr_e a);
   logic [`MSR_XLEN-1:0] v;
   case (a)
      A_PSR:    v = {{(`MSR_XLEN-`MSR_PSR_W){1'b0}}, m_psr};
      A_EPSR:   v = {{(`MSR_XLEN-`MSR_PSR_W){1'b0}}, m_epsr};
      A_EPC:    v = m_epc;
      A_ELSA:   v = m_elsa;
      A_EVECT:  v = m_evect;
      A_CPUID:  v = cpuid_word();
      A_SR0:    v = m_sr[0];
      A_SR1:    v = m_sr[1];
      A_SR2:    v = m_sr[2];
      A_SR3:    v = m_sr[3];
      default:  v = '0;
   endcase
   return v;
endfunction

function automatic msr_rsp_t predict_rsp(input msr_cmd_t c);
   msr_rsp_t r;
   r.op   = c.op;
   r.data = read_shadow(c.addr);
   case (c.op)
      OP_WRITE: begin
         case (c.addr)
            A_PSR:   m_psr = psr_image(c.data);
            A_EPSR:  m_epsr = psr_image(c.data);
            A_EPC:   m_epc = c.data;
            A_ELSA:  m_elsa = c.data;
            A_EVECT: m_evect = c.data & ~((64'd1 << `MSR_EVECT_LSB) - 64'd1);
            A_SR0:   m_sr[0] = c.data;
            A_SR1:   m_sr[1] = c.data;
            A_SR2:   m_sr[2] = c.data;
            A_SR3:   m_sr[3] = c.data;
            default: ;
         endcase
      end
      // Exception entry returns the handler address
      OP_SAVE: begin
         r.data     = m_evect;
         m_epsr     = m_psr;
         m_epc      = c.data;
         m_psr.rm   = 1'b1;
         m_psr.ire  = 1'b0;
         m_psr.imme = 1'b0;
         m_psr.dmme = 1'b0;
      end
      OP_RESTORE: begin
         r.data     = m_epc;
         m_psr.rm   = m_epsr.rm;
         m_psr.ire  = m_epsr.ire;
         m_psr.imme = m_epsr.imme;
         m_psr.dmme = m_epsr.dmme;
      end
      default: ;
   endcase
   return r;
endfunction

`endif

//--- tests/msr_unit_tb.sv
// Testbench for the machine-state unit
// Sends commands over the four-phase port, predicts every response
// with the reference model and checks responses in arrival order

`timescale 1ns/1ps
`default_nettype none

`include "msr_defines.svh"

module msr_unit_tb;
   import msr_pkg::*;

   `include "msr_model.svh"

   localparam int hs_limit    = 50;
   localparam int drain_limit = 200;
   // Edges from req to ack while the queue has room
   localparam int ack_latency = 2;

   logic     clk = 1'b0;
   logic     rst;
   logic     cmd_req;
   msr_cmd_t cmd;
   logic     cmd_ack;
   logic     rsp_valid;
   msr_rsp_t rsp;

   msr_rsp_t exp_q [$];
   int       checks;
   int       errors;
   int       rsp_count;
   int       tests_run;
   int       tests_ok;

   always #4 clk = ~clk;

   msr_unit dut_i (
      .clk       (clk),
      .rst       (rst),
      .cmd_req   (cmd_req),
      .cmd       (cmd),
      .cmd_ack   (cmd_ack),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

   task automatic check_value(input string what, input logic [127:0] got,
                              input logic [127:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("FAIL at %0t: %s, got %h, expected %h", $time, what, got, want);
      end
   endtask

   task automatic abort_run(input string why);
      $display("Run stopped at %0t: %s", $time, why);
      $display("tests failed");
      $finish;
   endtask

   // Responses are stable at the falling edge
   always @(negedge clk) begin
      msr_rsp_t want;
      if (rsp_valid === 1'b1) begin
         rsp_count++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("Response at %0t arrived with no command outstanding", $time);
         end else begin
            want = exp_q.pop_front();
            check_value($sformatf("response %0d, %s", rsp_count, want.op.name()),
                        rsp, want);
         end
      end
   end

   function automatic logic [`MSR_XLEN-1:0] rand64();
      return {$urandom, $urandom};
   endfunction

   function automatic msr_cmd_t make_cmd(input msr_op_e op, input msr_addr_e addr,
                                         input logic [`MSR_XLEN-1:0] data);
      msr_cmd_t c;
      c.op   = op;
      c.addr = addr;
      c.data = data;
      return c;
   endfunction

   // One four-phase transfer started 1 ns after a rising edge
   task automatic send_cmd(input msr_cmd_t c);
      int n;
      exp_q.push_back(predict_rsp(c));
      cmd     = c;
      cmd_req = 1'b1;
      n       = 0;
      while (!cmd_ack && n < hs_limit) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!cmd_ack) begin
         abort_run("cmd_ack never rose after cmd_req was raised");
      end
      check_value("cmd_ack latency in cycles", n, ack_latency);
      cmd_req = 1'b0;
      n       = 0;
      while (cmd_ack && n < hs_limit) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (cmd_ack) begin
         abort_run("cmd_ack stayed high after cmd_req was dropped");
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < drain_limit) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (exp_q.size() != 0) begin
         abort_run("responses missing for commands already accepted");
      end
   endtask

   task automatic finish_test(input string name, input int err_start);
      wait_drain();
      tests_run++;
      if (errors == err_start) begin
         tests_ok++;
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         $display("test %0d %s: %0d mismatches", tests_run, name, errors - err_start);
      end
   endtask

   // Reads every address including the unmapped codes
   task automatic reset_values();
      int e0;
      e0 = errors;
      for (int a = 0; a < 16; a++) begin
         send_cmd(make_cmd(OP_READ, msr_addr_e'(4'(a)), rand64()));
      end
      finish_test("reset values", e0);
   endtask

   task automatic write_read_back();
      msr_addr_e regs [$];
      int        e0;
      regs = '{A_PSR, A_EPSR, A_EPC, A_ELSA, A_EVECT, A_SR0, A_SR1, A_SR2, A_SR3};
      e0   = errors;
      foreach (regs[i]) begin
         repeat (2) begin
            send_cmd(make_cmd(OP_WRITE, regs[i], rand64()));
            send_cmd(make_cmd(OP_READ, regs[i], '0));
         end
      end
      // Read-only registers
      send_cmd(make_cmd(OP_WRITE, A_CPUID, rand64()));
      send_cmd(make_cmd(OP_READ, A_CPUID, '0));
      send_cmd(make_cmd(OP_WRITE, A_COREID, rand64()));
      send_cmd(make_cmd(OP_READ, A_COREID, '0));
      finish_test("write and read back", e0);
   endtask

   task automatic exception_entry();
      int e0;
      e0 = errors;
      send_cmd(make_cmd(OP_WRITE, A_PSR, 64'h3f0));
      send_cmd(make_cmd(OP_WRITE, A_EVECT, rand64()));
      send_cmd(make_cmd(OP_SAVE, A_PSR, rand64()));
      send_cmd(make_cmd(OP_READ, A_EPC, '0));
      send_cmd(make_cmd(OP_READ, A_EPSR, '0));
      send_cmd(make_cmd(OP_READ, A_PSR, '0));
      finish_test("exception entry", e0);
   endtask

   task automatic exception_return();
      int e0;
      e0 = errors;
      send_cmd(make_cmd(OP_WRITE, A_PSR, rand64()));
      send_cmd(make_cmd(OP_SAVE, A_SR0, rand64()));
      send_cmd(make_cmd(OP_WRITE, A_PSR, rand64()));
      send_cmd(make_cmd(OP_WRITE, A_PSR, rand64()));
      send_cmd(make_cmd(OP_RESTORE, A_PSR, rand64()));
      send_cmd(make_cmd(OP_READ, A_PSR, '0));
      send_cmd(make_cmd(OP_READ, A_EPSR, '0));
      send_cmd(make_cmd(OP_READ, A_EPC, '0));
      finish_test("exception return", e0);
   endtask

   // No drain between commands so several stay in flight
   task automatic random_burst();
      msr_op_e   op;
      msr_addr_e addr;
      int        e0;
      e0 = errors;
      for (int i = 0; i < 6 * `MSR_QUEUE_DEPTH; i++) begin
         op   = msr_op_e'(2'($urandom_range(0, 3)));
         addr = msr_addr_e'(4'($urandom_range(0, 15)));
         send_cmd(make_cmd(op, addr, rand64()));
      end
      finish_test("random back-to-back", e0);
   endtask

   initial begin
      void'($urandom(4));
      rst     = 1'b1;
      cmd_req = 1'b0;
      cmd     = '0;
      clear_shadow();
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      reset_values();
      write_read_back();
      exception_entry();
      exception_return();
      random_burst();
      $display("summary: %0d of %0d tests ok, %0d checks, %0d errors",
               tests_ok, tests_run, checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
+incdir+tests
verilog/msr_pkg.sv
verilog/msr_cmd_intake.sv
verilog/msr_cmd_queue.sv
verilog/msr_state.sv
verilog/msr_exec.sv
verilog/msr_unit.sv
tests/msr_unit_tb.sv
